/* common/cache_cfg.svh */
/* Geometry and message widths of the two-way write-back cache.
   Included by the package and by every module that sizes storage or ports. */

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ---------------------------------------------------------------------
// Message widths
// ---------------------------------------------------------------------

`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32
`define CACHE_LINE_W 128

// ---------------------------------------------------------------------
// Geometry
// ---------------------------------------------------------------------

`define CACHE_SETS 8
`define CACHE_WAYS 2
`define CACHE_OFS_W 4   // 16-byte lines
`define CACHE_IDX_W 3

// Whole address above the offset is kept as tag
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_OFS_W)
`define CACHE_WORDS (`CACHE_LINE_W / `CACHE_DATA_W)

`endif

/* common/cache_pkg.sv */
/* Message structs, address fields and control types shared by the cache RTL.
   Modules refer to these by scoped name. */

`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  // Read is 0 and write is 1 in every message
  typedef enum logic [2:0] {
    REQ_READ  = 3'd0,
    REQ_WRITE = 3'd1
  } req_type_t;

  typedef logic [`CACHE_IDX_W-1:0]  idx_t;
  typedef logic [`CACHE_TAG_W-1:0]  tag_t;
  typedef logic [`CACHE_OFS_W-1:0]  ofs_t;
  typedef logic [`CACHE_DATA_W-1:0] word_t;
  typedef logic [`CACHE_WORDS-1:0][`CACHE_DATA_W-1:0] line_t;  // Word 0 at the bottom

  typedef struct packed {
    tag_t tag;  // Index sits in the low tag bits
    ofs_t ofs;
  } addr_t;

  // ---------------------------------------------------------------------
  // Port messages
  // ---------------------------------------------------------------------

  typedef struct packed {
    req_type_t msg_type;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  typedef struct packed {
    req_type_t msg_type;
    logic      hit;
    word_t     data;
  } cache_resp_t;

  typedef struct packed {
    req_type_t msg_type;  // Write carries a victim line
    addr_t     addr;
    line_t     data;
  } mem_req_t;

  typedef struct packed {
    req_type_t msg_type;
    line_t     data;
  } mem_resp_t;

  // ---------------------------------------------------------------------
  // Control to datapath
  // ---------------------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    EVICT_PREPARE,
    EVICT_REQUEST,
    EVICT_WAIT,
    REFILL_REQUEST,
    REFILL_WAIT,
    REFILL_UPDATE,
    WAIT_RESP
  } ctrl_state_t;

  typedef struct packed {
    logic                    req_en;
    logic                    tag_wen;
    logic                    data_wen;
    logic [`CACHE_WORDS-1:0] wben;  // Words the write may touch
    logic                    refill_sel;
    logic                    mem_addr_sel;  // 1 picks the evict address
    logic                    evict_en;
    logic                    hit_en;
  } ctrl_t;

  typedef struct packed {
    logic [`CACHE_WAYS-1:0] way_hit;  // Raw tag match, no valid check
    logic                   victim;
  } dpath_status_t;

endpackage

`default_nettype wire

/* cache_dpath/cache_array.sv */
/* Set by way storage with one entry type, used for both tags and lines.
   Reads all ways of a set at once, writes one entry on the clock edge. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_array #(
  parameter type entry_t    = logic,
  parameter int  CACHE_WAYS = `CACHE_WAYS
) (
  input  logic                          clk,
  input  cache_pkg::idx_t               idx,
  input  logic [$clog2(CACHE_WAYS)-1:0] way,
  input  logic                          wen,
  input  entry_t                        wdata,
  output entry_t                        rdata [CACHE_WAYS]
);

  entry_t mem [`CACHE_SETS][CACHE_WAYS];

  always_ff @(posedge clk) begin
    if (wen) mem[idx][way] <= wdata;
  end

  // All ways out for the tag compare
  always_comb begin
    for (int w = 0; w < CACHE_WAYS; w++) begin
      rdata[w] = mem[idx][w];
    end
  end

endmodule

`default_nettype wire

/* cache_dpath/cache_dpath.sv */
/* Datapath of the blocking cache. Holds the request, the tag and data arrays,
   the evict register and builds the response and memory request messages. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  cache_pkg::cache_req_t    cachereq,
  input  cache_pkg::ctrl_t         ctrl,
  input  logic                     way_sel,
  input  cache_pkg::mem_resp_t     memresp,
  output cache_pkg::req_type_t     req_type,
  output cache_pkg::idx_t          req_idx,
  output cache_pkg::dpath_status_t status,
  output cache_pkg::cache_resp_t   cacheresp,
  output cache_pkg::mem_req_t      memreq
);

  cache_pkg::cache_req_t req_q;
  cache_pkg::tag_t       tag_rd [`CACHE_WAYS];
  cache_pkg::line_t      line_rd [`CACHE_WAYS];
  cache_pkg::line_t      line_wr;
  cache_pkg::tag_t       evict_tag;
  cache_pkg::line_t      evict_line;
  logic                  way_q;
  logic                  hit_q;
  logic [$clog2(`CACHE_WORDS)-1:0] word_idx;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_q <= cachereq;
  end

  assign req_type = req_q.msg_type;
  assign req_idx  = req_q.addr.tag[`CACHE_IDX_W-1:0];
  assign word_idx = req_q.addr.ofs[`CACHE_OFS_W-1:2];  // Byte offset to word

  // ---------------------------------------------------------------------
  // Arrays
  // ---------------------------------------------------------------------

  cache_array #(.entry_t(cache_pkg::tag_t)) tag_array (
    .clk   (clk),
    .idx   (req_idx),
    .way   (way_sel),
    .wen   (ctrl.tag_wen),
    .wdata (req_q.addr.tag),
    .rdata (tag_rd)
  );

  cache_array #(.entry_t(cache_pkg::line_t)) data_array (
    .clk   (clk),
    .idx   (req_idx),
    .way   (way_sel),
    .wen   (ctrl.data_wen),
    .wdata (line_wr),
    .rdata (line_rd)
  );

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      status.way_hit[w] = (tag_rd[w] == req_q.addr.tag);
    end
    status.victim = way_q;
  end

  // Refill takes the whole memory line, a store replaces one word
  always_comb begin
    line_wr = line_rd[way_sel];
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      if (ctrl.wben[i] && (ctrl.refill_sel || word_idx == i)) begin
        line_wr[i] = ctrl.refill_sel ? memresp.data[i] : req_q.data;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Way, hit and evict registers
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      way_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      if (ctrl.hit_en || ctrl.evict_en) way_q <= way_sel;
      if (ctrl.req_en) begin
        hit_q <= 1'b0;
      end else if (ctrl.hit_en) begin
        hit_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.evict_en) begin
      evict_tag  <= tag_rd[way_sel];
      evict_line <= line_rd[way_sel];
    end
  end

  always_comb begin
    memreq.addr.ofs = '0;  // Whole lines only
    if (ctrl.mem_addr_sel) begin
      memreq.msg_type = cache_pkg::REQ_WRITE;
      memreq.addr.tag = evict_tag;
      memreq.data     = evict_line;
    end else begin
      memreq.msg_type = cache_pkg::REQ_READ;
      memreq.addr.tag = req_q.addr.tag;
      memreq.data     = '0;
    end
  end

  always_comb begin
    cacheresp.msg_type = req_q.msg_type;
    cacheresp.hit      = hit_q;
    cacheresp.data     = '0;
    if (req_q.msg_type == cache_pkg::REQ_READ) begin
      cacheresp.data = line_rd[way_q][word_idx];
    end
  end

endmodule

`default_nettype wire

/* cache_ctrl/way_state.sv */
/* Valid, dirty and LRU bits of every set. Reads follow the set index
   combinationally, writes land on the next edge for the addressed way. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module way_state (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::idx_t        idx,
  input  logic                   way,
  input  logic                   valid_set,
  input  logic                   dirty_set,
  input  logic                   dirty_clear,
  input  logic                   lru_update,
  output logic [`CACHE_WAYS-1:0] valid,
  output logic [`CACHE_WAYS-1:0] dirty,
  output logic                   lru
);

  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty_q;
  logic [`CACHE_SETS-1:0]                  lru_q;  // Way to replace next

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (valid_set) valid_q[idx][way] <= 1'b1;
      if (dirty_set) begin
        dirty_q[idx][way] <= 1'b1;
      end else if (dirty_clear) begin
        dirty_q[idx][way] <= 1'b0;
      end
      if (lru_update) lru_q[idx] <= ~way;  // Other way becomes least recent
    end
  end

  assign valid = valid_q[idx];
  assign dirty = dirty_q[idx];
  assign lru   = lru_q[idx];

endmodule

`default_nettype wire

/* cache_ctrl/cache_ctrl.sv */
/* Control FSM of the blocking cache. Decides hit or miss, walks the
   evict and refill sequence and drives the datapath strobes each cycle. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                     clk,
  input  logic                     reset,

  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  input  logic                     memresp_val,
  output logic                     memresp_rdy,

  input  cache_pkg::req_type_t     req_type,
  input  cache_pkg::idx_t          req_idx,
  input  cache_pkg::dpath_status_t status,
  output cache_pkg::ctrl_t         ctrl,
  output logic                     way_sel
);

  localparam logic [`CACHE_WORDS-1:0] no_words  = '0;
  localparam logic [`CACHE_WORDS-1:0] all_words = '1;

  cache_pkg::ctrl_state_t state;
  cache_pkg::ctrl_state_t state_next;

  logic [`CACHE_WAYS-1:0] valid;
  logic [`CACHE_WAYS-1:0] dirty;
  logic [`CACHE_WAYS-1:0] hit_vec;
  logic                   lru;
  logic                   hit;
  logic                   victim_dirty;
  logic                   is_write;
  logic                   valid_set;
  logic                   dirty_set;
  logic                   dirty_clear;
  logic                   lru_update;

  way_state way_state0 (
    .clk         (clk),
    .reset       (reset),
    .idx         (req_idx),
    .way         (way_sel),
    .valid_set   (valid_set),
    .dirty_set   (dirty_set),
    .dirty_clear (dirty_clear),
    .lru_update  (lru_update),
    .valid       (valid),
    .dirty       (dirty),
    .lru         (lru)
  );

  // Hit needs a tag match on a valid way
  assign hit_vec      = status.way_hit & valid;
  assign hit          = |hit_vec;
  assign victim_dirty = valid[lru] && dirty[lru];
  assign is_write     = (req_type == cache_pkg::REQ_WRITE);

  // Way is chosen in TAG_CHECK, then held in the datapath
  always_comb begin
    if (state == cache_pkg::TAG_CHECK) begin
      way_sel = hit ? hit_vec[1] : lru;
    end else begin
      way_sel = status.victim;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ---------------------------------------------------------------------
  // Next state
  // ---------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::IDLE:           if (cachereq_val) state_next = cache_pkg::TAG_CHECK;
      cache_pkg::TAG_CHECK: begin
        if (hit) begin
          state_next = is_write ? cache_pkg::WRITE_ACCESS : cache_pkg::READ_ACCESS;
        end else if (victim_dirty) begin
          state_next = cache_pkg::EVICT_PREPARE;
        end else begin
          state_next = cache_pkg::REFILL_REQUEST;
        end
      end
      cache_pkg::READ_ACCESS:    state_next = cache_pkg::WAIT_RESP;
      cache_pkg::WRITE_ACCESS:   state_next = cache_pkg::WAIT_RESP;
      cache_pkg::EVICT_PREPARE:  state_next = cache_pkg::EVICT_REQUEST;
      cache_pkg::EVICT_REQUEST:  if (memreq_rdy) state_next = cache_pkg::EVICT_WAIT;
      cache_pkg::EVICT_WAIT:     if (memresp_val) state_next = cache_pkg::REFILL_REQUEST;
      cache_pkg::REFILL_REQUEST: if (memreq_rdy) state_next = cache_pkg::REFILL_WAIT;
      cache_pkg::REFILL_WAIT:    if (memresp_val) state_next = cache_pkg::REFILL_UPDATE;
      cache_pkg::REFILL_UPDATE:
        state_next = is_write ? cache_pkg::WRITE_ACCESS : cache_pkg::READ_ACCESS;
      cache_pkg::WAIT_RESP:      if (cacheresp_rdy) state_next = cache_pkg::IDLE;
      default:                   state_next = cache_pkg::IDLE;
    endcase
  end

  // ---------------------------------------------------------------------
  // Control table
  // ---------------------------------------------------------------------

  function automatic cache_pkg::ctrl_t cs(
    input logic                    req_en,
    input logic                    tag_wen,
    input logic                    data_wen,
    input logic [`CACHE_WORDS-1:0] wben,
    input logic                    refill_sel,
    input logic                    mem_addr_sel,
    input logic                    evict_en,
    input logic                    hit_en
  );
    return {req_en, tag_wen, data_wen, wben, refill_sel, mem_addr_sel, evict_en, hit_en};
  endfunction

  always_comb begin
    case (state)
      //                                   req           tag          data
      //                                   wben       refill maddr evict hit
      cache_pkg::IDLE:           ctrl = cs(cachereq_val, 1'b0,        1'b0,
                                           no_words,  1'b0,  1'b0, 1'b0, 1'b0);
      cache_pkg::TAG_CHECK:      ctrl = cs(1'b0,         1'b0,        1'b0,
                                           no_words,  1'b0,  1'b0, !hit, hit);
      cache_pkg::WRITE_ACCESS:   ctrl = cs(1'b0,         1'b0,        1'b1,
                                           all_words, 1'b0,  1'b0, 1'b0, 1'b0);
      cache_pkg::EVICT_REQUEST:  ctrl = cs(1'b0,         1'b0,        1'b0,
                                           no_words,  1'b0,  1'b1, 1'b0, 1'b0);
      cache_pkg::REFILL_WAIT:    ctrl = cs(1'b0,         memresp_val, memresp_val,
                                           all_words, 1'b1,  1'b0, 1'b0, 1'b0);
      default:                   ctrl = cs(1'b0,         1'b0,        1'b0,
                                           no_words,  1'b0,  1'b0, 1'b0, 1'b0);
    endcase
  end

  // Handshakes and way bit strobes
  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    valid_set     = 1'b0;
    dirty_set     = 1'b0;
    dirty_clear   = 1'b0;
    lru_update    = 1'b0;
    case (state)
      cache_pkg::IDLE:         cachereq_rdy = 1'b1;
      cache_pkg::READ_ACCESS:  lru_update = 1'b1;
      cache_pkg::WRITE_ACCESS: begin
        lru_update = 1'b1;
        dirty_set  = 1'b1;
      end
      cache_pkg::EVICT_REQUEST, cache_pkg::REFILL_REQUEST: memreq_val = 1'b1;
      cache_pkg::EVICT_WAIT, cache_pkg::REFILL_WAIT:       memresp_rdy = 1'b1;
      cache_pkg::REFILL_UPDATE: begin
        valid_set   = 1'b1;  // Fresh line is clean
        dirty_clear = 1'b1;
      end
      cache_pkg::WAIT_RESP:    cacheresp_val = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/blocking_cache.sv */
/* Top of the blocking two-way write-back cache.
   Joins the control unit and the datapath to the four val/rdy ports. */

`timescale 1ns/1ps
`default_nettype none

module blocking_cache (
  input  logic                   clk,
  input  logic                   reset,

  input  cache_pkg::cache_req_t  cachereq,
  input  logic                   cachereq_val,
  output logic                   cachereq_rdy,

  output cache_pkg::cache_resp_t cacheresp,
  output logic                   cacheresp_val,
  input  logic                   cacheresp_rdy,

  output cache_pkg::mem_req_t    memreq,
  output logic                   memreq_val,
  input  logic                   memreq_rdy,

  input  cache_pkg::mem_resp_t   memresp,
  input  logic                   memresp_val,
  output logic                   memresp_rdy
);

  cache_pkg::ctrl_t         ctrl;
  cache_pkg::dpath_status_t status;
  cache_pkg::req_type_t     req_type;
  cache_pkg::idx_t          req_idx;
  logic                     way_sel;

  cache_ctrl ctrl0 (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_type      (req_type),
    .req_idx       (req_idx),
    .status        (status),
    .ctrl          (ctrl),
    .way_sel       (way_sel)
  );

  cache_dpath dpath0 (
    .clk       (clk),
    .reset     (reset),
    .cachereq  (cachereq),
    .ctrl      (ctrl),
    .way_sel   (way_sel),
    .memresp   (memresp),
    .req_type  (req_type),
    .req_idx   (req_idx),
    .status    (status),
    .cacheresp (cacheresp),
    .memreq    (memreq)
  );

endmodule

`default_nettype wire

/* dv/cache_checker.sv */
/* Checker for the blocking cache testbench. Watches the ports, keeps a shadow
   of memory from accepted writes and compares responses and write-backs. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::cache_req_t  cachereq,
  input  logic                   cachereq_val,
  input  logic                   cachereq_rdy,
  input  cache_pkg::cache_resp_t cacheresp,
  input  logic                   cacheresp_val,
  input  logic                   cacheresp_rdy,
  input  cache_pkg::mem_req_t    memreq,
  input  logic                   memreq_val,
  input  logic                   memreq_rdy,
  input  logic                   memresp_rdy,
  input  logic                   hit_check,
  input  logic                   hit_expect,
  input  logic                   test_done,
  input  int                     test_id,
  input  int                     expect_wbs,
  input  logic                   all_done,
  output int                     error_count
);

  logic [31:0]           shadow [256];  // Word view of the 1 KB space
  cache_pkg::cache_req_t cur;
  logic                  reset_q;
  logic                  chk_q;
  logic                  exp_q;
  logic                  saw_memreq;
  int                    lat;           // Edges since acceptance
  int                    resp_lat;
  int                    pass_count;
  int                    test_checks;
  int                    test_errors;
  int                    test_wbs;

  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return (addr * 32'h2545f491) ^ {addr[15:0], addr[31:16]} ^ 32'hc3a50f1e;
  endfunction

  // Last accepted write to the word or else its fill pattern
  function automatic logic [31:0] ref_read_word(input logic [31:0] addr);
    return shadow[addr[9:2]];
  endfunction

  task automatic tally(input logic ok);
    test_checks++;
    if (ok) begin
      pass_count++;
    end else begin
      error_count++;
      test_errors++;
    end
  endtask

  always @(posedge clk) begin
    logic ok;
    reset_q <= reset;
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        shadow[i] = initial_word(32'(i * 4));
      end
      error_count = 0;
      pass_count  = 0;
      test_checks = 0;
      test_errors = 0;
      test_wbs    = 0;
      lat         = 0;
      resp_lat    = -1;
      saw_memreq  = 1'b0;
      chk_q       = 1'b0;
      exp_q       = 1'b0;
      cur         = '0;
    end else begin
      if (reset_q) begin  // First edge out of reset
        ok = cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy;
        tally(ok);
        if (!ok) $display("[ERROR] %0t: ports not idle after reset", $time);
      end

      // ------------------------------------------------------------------
      // Request tracking
      // ------------------------------------------------------------------
      if (cachereq_val && cachereq_rdy) begin
        cur        = cachereq;
        chk_q      = hit_check;
        exp_q      = hit_expect;
        lat        = 0;
        resp_lat   = -1;
        saw_memreq = 1'b0;
        if (cachereq.msg_type == cache_pkg::REQ_WRITE) begin
          shadow[cachereq.addr[9:2]] = cachereq.data;
        end
      end else begin
        lat++;
        if (memreq_val) saw_memreq = 1'b1;
        if (cacheresp_val && resp_lat < 0) resp_lat = lat;
      end

      if (cacheresp_val && cacheresp_rdy) begin
        ok = (cacheresp.msg_type == cur.msg_type);
        if (ok && cur.msg_type == cache_pkg::REQ_READ) begin
          ok = (cacheresp.data == ref_read_word(cur.addr));
        end
        tally(ok);
        if (!ok) begin
          $display("[ERROR] %0t: response to 0x%08h type %0d data 0x%08h, expected 0x%08h",
                   $time, cur.addr, cacheresp.msg_type, cacheresp.data,
                   ref_read_word(cur.addr));
        end
        if (chk_q) begin
          ok = (cacheresp.hit == exp_q);
          if (exp_q) ok = ok && (resp_lat == 3) && !saw_memreq;  // Hit path is fixed
          tally(ok);
          if (!ok) begin
            $display("[ERROR] %0t: 0x%08h hit %0b after %0d cycles memreq %0b, expected hit %0b",
                     $time, cur.addr, cacheresp.hit, resp_lat, saw_memreq, exp_q);
          end
        end
      end

      // Victim line against the shadow
      if (memreq_val && memreq_rdy && memreq.msg_type == cache_pkg::REQ_WRITE) begin
        test_wbs++;
        for (int k = 0; k < `CACHE_WORDS; k++) begin
          ok = (memreq.data[k] == ref_read_word(memreq.addr + 32'(k * 4)));
          tally(ok);
          if (!ok) begin
            $display("[ERROR] %0t: write-back 0x%08h word %0d is 0x%08h, expected 0x%08h",
                     $time, memreq.addr, k, memreq.data[k],
                     ref_read_word(memreq.addr + 32'(k * 4)));
          end
        end
      end

      if (test_done) begin
        if (expect_wbs >= 0) begin
          ok = (test_wbs == expect_wbs);
          tally(ok);
          if (!ok) begin
            $display("[ERROR] %0t: test %0d saw %0d write-backs, expected %0d",
                     $time, test_id, test_wbs, expect_wbs);
          end
        end
        $display("Test %0d finished: %0d checks, %0d failed, %0d write-backs",
                 test_id, test_checks, test_errors, test_wbs);
        test_checks = 0;
        test_errors = 0;
        test_wbs    = 0;
      end
      if (all_done) $display("Checks passed: %0d, failed: %0d", pass_count, error_count);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_blocking_cache.sv */
/* Testbench top for the blocking cache. Drives requests, models memory with
   random ready delays and leaves all comparing to the checker. */

`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_blocking_cache;

  localparam logic [31:0] lcg_seed       = 32'h3704efc0;
  localparam int          timeout_cycles = 200;  // Per wait loop
  localparam int          mem_lines      = 64;   // 1 KB backing store

  logic                   clk;
  logic                   reset;
  cache_pkg::cache_req_t  cachereq;
  logic                   cachereq_val;
  logic                   cachereq_rdy;
  cache_pkg::cache_resp_t cacheresp;
  logic                   cacheresp_val;
  logic                   cacheresp_rdy;
  cache_pkg::mem_req_t    memreq;
  logic                   memreq_val;
  logic                   memreq_rdy;
  cache_pkg::mem_resp_t   memresp;
  logic                   memresp_val;
  logic                   memresp_rdy;

  logic                   hit_check;
  logic                   hit_expect;
  logic                   test_done;
  int                     test_id;
  int                     expect_wbs;  // -1 when the count is free
  logic                   all_done;
  int                     error_count;
  logic                   timed_out;
  logic [31:0]            stim_state;
  cache_pkg::line_t       mem [mem_lines];

  blocking_cache dut0 (
    .clk           (clk),
    .reset         (reset),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq        (memreq),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp       (memresp),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy)
  );

  cache_checker check0 (
    .clk           (clk),
    .reset         (reset),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq        (memreq),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_rdy   (memresp_rdy),
    .hit_check     (hit_check),
    .hit_expect    (hit_expect),
    .test_done     (test_done),
    .test_id       (test_id),
    .expect_wbs    (expect_wbs),
    .all_done      (all_done),
    .error_count   (error_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory contents before any write-back
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h2545f491) ^ {addr[15:0], addr[31:16]} ^ 32'hc3a50f1e;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Memory model answering one request at a time and in order
  // ----------------------------------------------------------------------

  initial begin
    logic                req_fire;
    logic                resp_fire;
    logic                armed;
    int                  delay;
    logic [31:0]         mem_state;
    cache_pkg::mem_req_t req;
    for (int l = 0; l < mem_lines; l++) begin
      for (int k = 0; k < `CACHE_WORDS; k++) begin
        mem[l][k] = fill_word(32'(l * 16 + k * 4));
      end
    end
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    mem_state   = lcg_seed;
    armed       = 1'b0;
    delay       = 0;
    forever begin
      @(posedge clk);
      req_fire  = memreq_val && memreq_rdy;
      resp_fire = memresp_val && memresp_rdy;
      req       = memreq;
      #2;
      if (resp_fire) memresp_val = 1'b0;
      if (req_fire) begin
        memreq_rdy       = 1'b0;
        armed            = 1'b0;
        memresp.msg_type = req.msg_type;
        if (req.msg_type == cache_pkg::REQ_WRITE) begin
          mem[req.addr[9:4]] = req.data;  // Victim line lands here
          memresp.data       = '0;
        end else begin
          memresp.data = mem[req.addr[9:4]];
        end
        memresp_val = 1'b1;
      end else if (memreq_val && !memresp_val) begin
        if (!armed) begin
          mem_state = lcg_next(mem_state);
          delay     = int'(mem_state[31:30]);  // 0 to 3 cycles
          armed     = 1'b1;
        end
        if (delay == 0) begin
          memreq_rdy = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles at %0t", what, timeout_cycles, $time);
    timed_out = 1'b1;
  endtask

  // One request, then hold cacheresp_rdy low for stall cycles of a valid response
  task automatic do_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic chk, input logic exp_hit, input int stall);
    int   t;
    int   left;
    logic fired;
    logic seen;
    if (timed_out) return;
    cachereq.msg_type = wr ? cache_pkg::REQ_WRITE : cache_pkg::REQ_READ;
    cachereq.addr     = addr;
    cachereq.data     = wdata;
    cachereq_val      = 1'b1;
    hit_check         = chk;
    hit_expect        = exp_hit;
    cacheresp_rdy     = (stall == 0);
    left              = stall;
    t                 = 0;
    fired             = 1'b0;
    while (!fired && t < timeout_cycles) begin
      @(posedge clk);
      fired = cachereq_rdy;
      t++;
      #2;
    end
    cachereq_val = 1'b0;
    if (!fired) begin
      report_timeout("request accept");
      return;
    end
    t     = 0;
    fired = 1'b0;
    while (!fired && t < timeout_cycles) begin
      @(posedge clk);
      fired = cacheresp_val && cacheresp_rdy;
      seen  = cacheresp_val;
      t++;
      #2;
      if (seen && !fired) begin
        if (left > 0) left--;
        if (left == 0) cacheresp_rdy = 1'b1;
      end
    end
    cacheresp_rdy = 1'b0;
    if (!fired) report_timeout("cache response");
  endtask

  task automatic finish_test(input int id, input int wbs);
    if (timed_out) return;
    test_id    = id;
    expect_wbs = wbs;
    test_done  = 1'b1;
    @(posedge clk);
    #2;
    test_done = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] addr;
    logic        wr;
    int          stall;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b0;
    hit_check     = 1'b0;
    hit_expect    = 1'b0;
    test_done     = 1'b0;
    test_id       = 0;
    expect_wbs    = -1;
    all_done      = 1'b0;
    timed_out     = 1'b0;
    stim_state    = lcg_seed;
    reset         = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);  // Checker looks at idle ports here
    #2;

    // Cold read miss in set 0
    do_access(1'b0, 32'h0000_0104, 32'h0, 1'b1, 1'b0, 0);
    finish_test(1, 0);

    // Write then read hits in set 1
    do_access(1'b1, 32'h0000_0218, 32'hcafe_0001, 1'b0, 1'b0, 0);
    do_access(1'b0, 32'h0000_0218, 32'h0, 1'b1, 1'b1, 0);
    do_access(1'b1, 32'h0000_021c, 32'hcafe_0002, 1'b1, 1'b1, 0);
    do_access(1'b0, 32'h0000_021c, 32'h0, 1'b1, 1'b1, 0);
    finish_test(2, 0);

    // Three dirty lines in set 2, then the first one again
    do_access(1'b1, 32'h0000_0024, 32'h1111_0024, 1'b1, 1'b0, 0);
    do_access(1'b1, 32'h0000_00a4, 32'h2222_00a4, 1'b1, 1'b0, 0);
    do_access(1'b1, 32'h0000_0124, 32'h3333_0124, 1'b1, 1'b0, 0);
    do_access(1'b0, 32'h0000_0024, 32'h0, 1'b1, 1'b0, 0);
    finish_test(3, 2);

    // A B A then C in set 3 evicts B
    do_access(1'b1, 32'h0000_0034, 32'haaaa_0034, 1'b1, 1'b0, 0);
    do_access(1'b1, 32'h0000_00b4, 32'hbbbb_00b4, 1'b1, 1'b0, 0);
    do_access(1'b0, 32'h0000_0034, 32'h0, 1'b1, 1'b1, 0);
    do_access(1'b1, 32'h0000_0134, 32'hcccc_0134, 1'b1, 1'b0, 0);
    do_access(1'b0, 32'h0000_0034, 32'h0, 1'b1, 1'b1, 0);
    do_access(1'b0, 32'h0000_00b4, 32'h0, 1'b1, 1'b0, 0);
    finish_test(4, 2);

    // Random traffic over 64 lines with response stalls
    for (int n = 0; n < 200; n++) begin
      stim_state = lcg_next(stim_state);
      addr       = {22'd0, stim_state[29:22], 2'b00};
      wr         = stim_state[31];
      stall      = int'(stim_state[21:20]);
      stim_state = lcg_next(stim_state);
      do_access(wr, addr, stim_state, 1'b0, 1'b0, stall);
    end
    finish_test(5, -1);

    all_done = 1'b1;
    @(posedge clk);
    #2;
    all_done = 1'b0;
    if (timed_out || error_count != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* blocking_cache.f */
+incdir+common
common/cache_pkg.sv
cache_dpath/cache_array.sv
cache_dpath/cache_dpath.sv
cache_ctrl/way_state.sv
cache_ctrl/cache_ctrl.sv
design/blocking_cache.sv
dv/cache_checker.sv
dv/tb_blocking_cache.sv

/* run.sh */
#!/bin/sh
# Compile the blocking cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_blocking_cache -f blocking_cache.f

out=$(./obj_dir/Vtb_blocking_cache)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1
